// ==== hdl/dsc_dma_pkg.sv ====
package dsc_dma_pkg;

	typedef logic [31:0] addr_t;     // byte address
	typedef logic [27:0] byte_cnt_t; // never zero in a valid descriptor
	typedef logic [63:0] dsc_word_t; // raw word as read over axi
	typedef logic [1:0]  tgt_t;      // 0 feature map, 1 kernel, 2 linear, 3 invalid
	typedef logic [1:0]  chan_t;
	typedef logic [8:0]  cmd_len_t;  // 1 to 256 bytes

	// overlays one dsc_word_t
	typedef struct packed {
		byte_cnt_t   byte_cnt; // 63:36
		logic [1:0]  pkt_info; // 35:34
		tgt_t        tgt;      // 33:32
		addr_t       addr;     // 31:0
	} rd_dsc_t;

	typedef struct packed {
		addr_t       addr;
		cmd_len_t    len;
		logic [1:0]  pkt_info;
		logic        last;     // final command of its descriptor
	} burst_cmd_t;

	typedef enum logic {
		SPLIT_IDLE,
		SPLIT_BUSY
	} split_state_t;

	localparam int DSC_BURST_LEN = 8;    // beats per AR burst
	localparam int DSC_BUF_DEPTH = 32;   // descriptor words buffered
	localparam int MAX_REQ_N     = 1024;
	localparam int CHAN_N        = 3;
	localparam int CMD_MAX_BYTES = 256;

endpackage

// ==== hdl/rw_req_dsc_fetch.sv ====
module rw_req_dsc_fetch (
	input  logic               clk,
	input  logic               rst_n,
	input  dsc_dma_pkg::addr_t req_buf_baseaddr, // table base, 64 byte aligned
	input  logic [31:0]        req_n,            // descriptor count minus 1
	input  logic               blk_start,
	input  logic               arready,
	input  logic               rvalid,           // r beat accepted by the buffer
	input  logic               rlast,
	input  logic               fifo_pop_last,    // last word of a burst left the buffer
	output logic               blk_idle,
	output logic               blk_done,
	output dsc_dma_pkg::addr_t araddr,
	output logic [7:0]         arlen,
	output logic               arvalid,
	output logic               in_flight_full
);
	import dsc_dma_pkg::*;

	localparam int REM_W       = $clog2(MAX_REQ_N);
	localparam int BURST_LIMIT = DSC_BUF_DEPTH / DSC_BURST_LEN; // bursts the buffer can absorb
	localparam int CNT_W       = $clog2(BURST_LIMIT) + 1;
	localparam int ALIGN_W     = $clog2(DSC_BURST_LEN * 8);

	logic             start_acc;  // start taken this cycle
	logic             ar_hs;
	logic             r_last_hs;
	logic [REM_W-1:0] req_rem;    // descriptors left minus 1
	logic [REM_W-1:0] arlen_cmp;
	logic             ar_last;    // next AR is the final one
	logic             last_burst; // open burst is the final one
	logic             burst_open;
	logic [CNT_W-1:0] in_flight;  // launched but not drained from the buffer

	assign start_acc = blk_start & blk_idle;
	assign ar_hs     = arvalid & arready;
	assign r_last_hs = rvalid & rlast;
	assign blk_done  = r_last_hs & last_burst;

	// at start the count comes straight from the port
	assign arlen_cmp = start_acc ? req_n[REM_W-1:0] : req_rem;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			blk_idle <= 1'b1;
		else
			blk_idle <= blk_idle ? ~blk_start : blk_done;
	end

	// AR payload, loaded at start and stepped on each handshake
	always_ff @(posedge clk)
	begin
		if (start_acc || ar_hs)
		begin
			araddr  <= start_acc ? req_buf_baseaddr : araddr + addr_t'(DSC_BURST_LEN * 8);
			arlen   <= (arlen_cmp <= REM_W'(DSC_BURST_LEN - 1)) ?
				8'(arlen_cmp) : 8'(DSC_BURST_LEN - 1);
			req_rem <= arlen_cmp - REM_W'(DSC_BURST_LEN); // wraps after the final burst
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ar_last <= 1'b0;
		else if (start_acc || ar_hs)
			ar_last <= arlen_cmp <= REM_W'(DSC_BURST_LEN - 1);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			last_burst <= 1'b0;
		else if (ar_hs)
			last_burst <= ar_last;
	end

	// one burst outstanding at a time
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			burst_open <= 1'b0;
		else if (ar_hs || r_last_hs)
			burst_open <= ar_hs; // ar and rlast never coincide
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			arvalid <= 1'b0;
		else if (arvalid)
			arvalid <= ~arready; // hold until taken
		else
			arvalid <= ~blk_idle & ~in_flight_full & ~burst_open;
	end

	// buffer room in whole bursts
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			in_flight <= '0;
		else if (ar_hs ^ fifo_pop_last)
			in_flight <= ar_hs ? in_flight + 1'b1 : in_flight - 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			in_flight_full <= 1'b0;
		else if (ar_hs ^ fifo_pop_last)
			in_flight_full <= ar_hs & (in_flight == CNT_W'(BURST_LIMIT - 1));
	end

	// bursts never cross a 4KB boundary this way
	a_ar_align: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid |-> araddr[ALIGN_W-1:0] == '0);

	a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

endmodule

// ==== hdl/dsc_fifo.sv ====
module dsc_fifo (
	input  logic                   clk,
	input  logic                   rst_n,
	input  dsc_dma_pkg::dsc_word_t in_data,
	input  logic                   in_last,
	input  logic                   in_valid,
	output logic                   in_ready,
	output dsc_dma_pkg::dsc_word_t out_data,
	output logic                   out_last,
	output logic                   out_valid,
	input  logic                   out_ready
);
	import dsc_dma_pkg::*;

	localparam int PTR_W = $clog2(DSC_BUF_DEPTH);

	dsc_word_t      mem_data [DSC_BUF_DEPTH];
	logic           mem_last [DSC_BUF_DEPTH];
	logic [PTR_W-1:0] wptr;
	logic [PTR_W-1:0] rptr;
	logic [PTR_W:0] mem_cnt; // words behind the output register
	logic           wr_en;
	logic           out_load;
	logic           bypass;  // empty memory, word goes straight to the output
	logic           mem_wr;
	logic           mem_rd;

	// output register counts as one slot
	assign in_ready = !(out_valid && mem_cnt == (PTR_W + 1)'(DSC_BUF_DEPTH - 1));
	assign wr_en    = in_valid & in_ready;
	assign out_load = (~out_valid | out_ready) & ((mem_cnt != '0) | wr_en);
	assign bypass   = out_load & (mem_cnt == '0);
	assign mem_wr   = wr_en & ~bypass;
	assign mem_rd   = out_load & ~bypass;

	always_ff @(posedge clk)
	begin
		if (mem_wr)
		begin
			mem_data[wptr] <= in_data;
			mem_last[wptr] <= in_last;
		end
		if (out_load)
		begin
			out_data <= bypass ? in_data : mem_data[rptr];
			out_last <= bypass ? in_last : mem_last[rptr];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wptr      <= '0;
			rptr      <= '0;
			mem_cnt   <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			wptr    <= wptr + PTR_W'(mem_wr);  // pointers wrap, depth is a power of 2
			rptr    <= rptr + PTR_W'(mem_rd);
			mem_cnt <= mem_cnt + (PTR_W + 1)'(mem_wr) - (PTR_W + 1)'(mem_rd);
			if (out_load)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	// the burst budget upstream keeps a beat from meeting a full buffer
	a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> in_ready);

endmodule

// ==== hdl/dsc_dispatch.sv ====
module dsc_dispatch (
	input  logic                            clk,
	input  logic                            rst_n,
	input  dsc_dma_pkg::dsc_word_t          in_data,
	input  logic                            in_valid,
	output logic                            in_ready,
	output dsc_dma_pkg::rd_dsc_t            chan_dsc,   // shared by all splitters
	output logic [dsc_dma_pkg::CHAN_N-1:0]  chan_valid,
	input  logic [dsc_dma_pkg::CHAN_N-1:0]  chan_ready
);
	import dsc_dma_pkg::*;

	rd_dsc_t in_dsc;
	logic    hold_valid;
	logic    taken;      // held item leaves this cycle

	assign in_dsc   = rd_dsc_t'(in_data);
	assign taken    = |(chan_valid & chan_ready);
	assign in_ready = ~hold_valid | taken;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hold_valid <= 1'b0;
		else if (in_ready)
			hold_valid <= in_valid & (in_dsc.tgt != tgt_t'(3)); // target 3 is swallowed here
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			chan_dsc <= in_dsc;
	end

	// route by target
	always_comb
	begin
		for (int i = 0; i < CHAN_N; i++)
			chan_valid[i] = hold_valid && (chan_dsc.tgt == tgt_t'(i));
	end

	// target 3 is never held
	a_route_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		hold_valid |-> $onehot(chan_valid));

endmodule

// ==== hdl/burst_cmd_splitter.sv ====
module burst_cmd_splitter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  dsc_dma_pkg::rd_dsc_t    dsc,
	input  logic                    dsc_valid,
	output logic                    dsc_ready,
	output dsc_dma_pkg::burst_cmd_t cmd,
	output logic                    cmd_valid,
	input  logic                    cmd_ready
);
	import dsc_dma_pkg::*;

	split_state_t state;
	addr_t        cur_addr;
	byte_cnt_t    rem;       // bytes not yet issued
	logic [1:0]   pkt_info;
	logic         fits;      // remainder fits one command

	assign dsc_ready = state == SPLIT_IDLE;
	assign cmd_valid = state == SPLIT_BUSY;
	assign fits      = rem <= byte_cnt_t'(CMD_MAX_BYTES);

	always_comb
	begin
		cmd.addr     = cur_addr;
		cmd.len      = fits ? cmd_len_t'(rem) : cmd_len_t'(CMD_MAX_BYTES);
		cmd.pkt_info = pkt_info;
		cmd.last     = fits;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= SPLIT_IDLE;
		else
		begin
			case (state)
				SPLIT_IDLE:
				begin
					if (dsc_valid)
						state <= SPLIT_BUSY;
				end
				SPLIT_BUSY:
				begin
					if (cmd_ready && fits)
						state <= SPLIT_IDLE; // last command taken
				end
				default:
					state <= SPLIT_IDLE;
			endcase
		end
	end

	// walk the byte range in 256 byte steps
	always_ff @(posedge clk)
	begin
		if (dsc_valid && dsc_ready)
		begin
			cur_addr <= dsc.addr;
			rem      <= dsc.byte_cnt;
			pkt_info <= dsc.pkt_info;
		end
		else if (cmd_valid && cmd_ready)
		begin
			cur_addr <= cur_addr + addr_t'(CMD_MAX_BYTES);
			rem      <= rem - byte_cnt_t'(CMD_MAX_BYTES); // dead value after the last
		end
	end

endmodule

// ==== hdl/cmd_arbiter.sv ====
module cmd_arbiter (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  dsc_dma_pkg::burst_cmd_t [dsc_dma_pkg::CHAN_N-1:0]   in_cmd,
	input  logic [dsc_dma_pkg::CHAN_N-1:0]                      in_valid,
	output logic [dsc_dma_pkg::CHAN_N-1:0]                      in_ready,
	output dsc_dma_pkg::burst_cmd_t                             out_cmd,
	output dsc_dma_pkg::chan_t                                  out_chan,
	output logic                                                out_valid,
	input  logic                                                out_ready
);
	import dsc_dma_pkg::*;

	logic [CHAN_N-1:0] rr_grant;
	logic [CHAN_N-1:0] held_grant;
	logic [CHAN_N-1:0] grant;
	logic              hold_active; // stalled grant from last cycle
	chan_t             ptr;         // channel with top priority

	// first requester at or after ptr, lowest offset wins
	always_comb
	begin
		int idx;
		rr_grant = '0;
		for (int k = CHAN_N - 1; k >= 0; k--)
		begin
			idx = (int'(ptr) + k) % CHAN_N;
			if (in_valid[idx])
			begin
				rr_grant      = '0;
				rr_grant[idx] = 1'b1;
			end
		end
	end

	assign grant     = hold_active ? held_grant : rr_grant;
	assign out_valid = |(grant & in_valid);
	assign in_ready  = grant & {CHAN_N{out_ready}};

	always_comb
	begin
		out_cmd  = '0;
		out_chan = '0;
		for (int i = 0; i < CHAN_N; i++)
		begin
			if (grant[i])
			begin
				out_cmd  = in_cmd[i];
				out_chan = chan_t'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hold_active <= 1'b0;
			ptr         <= '0;
		end
		else
		begin
			hold_active <= out_valid & ~out_ready;
			if (out_valid && out_ready)
				ptr <= (out_chan == chan_t'(CHAN_N - 1)) ? '0 : out_chan + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		held_grant <= grant;
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $onehot(grant));

	// relies on the splitters holding valid
	a_grant_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && out_chan == $past(out_chan));

endmodule

// ==== hdl/dsc_dma_top.sv ====
module dsc_dma_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  dsc_dma_pkg::addr_t      req_buf_baseaddr,
	input  logic [31:0]             req_n,
	input  logic                    blk_start,
	output logic                    blk_idle,
	output logic                    blk_done,
	output dsc_dma_pkg::addr_t      m_axi_araddr,
	output logic [1:0]              m_axi_arburst,
	output logic [7:0]              m_axi_arlen,
	output logic [2:0]              m_axi_arsize,
	output logic                    m_axi_arvalid,
	input  logic                    m_axi_arready,
	input  dsc_dma_pkg::dsc_word_t  m_axi_rdata,
	input  logic [1:0]              m_axi_rresp, // ignored
	input  logic                    m_axi_rlast,
	input  logic                    m_axi_rvalid,
	output logic                    m_axi_rready,
	output dsc_dma_pkg::burst_cmd_t cmd,
	output dsc_dma_pkg::chan_t      cmd_chan,
	output logic                    cmd_valid,
	input  logic                    cmd_ready
);
	import dsc_dma_pkg::*;

	logic                           r_hs;          // r beat into the buffer
	logic                           in_flight_full;
	logic                           fifo_pop_last;
	dsc_word_t                      fifo_data;
	logic                           fifo_last;
	logic                           fifo_valid;
	logic                           fifo_ready;
	rd_dsc_t                        chan_dsc;
	logic [CHAN_N-1:0]              chan_valid;
	logic [CHAN_N-1:0]              chan_ready;
	burst_cmd_t [CHAN_N-1:0]        split_cmd;
	logic [CHAN_N-1:0]              split_valid;
	logic [CHAN_N-1:0]              split_ready;

	assign m_axi_arburst = 2'b01;  // INCR
	assign m_axi_arsize  = 3'b011; // 8 bytes per beat
	assign r_hs          = m_axi_rvalid & m_axi_rready;
	assign fifo_pop_last = fifo_valid & fifo_ready & fifo_last;

	rw_req_dsc_fetch u_fetch (
		.clk(clk), .rst_n(rst_n),
		.req_buf_baseaddr(req_buf_baseaddr), .req_n(req_n),
		.blk_start(blk_start), .arready(m_axi_arready),
		.rvalid(r_hs), .rlast(m_axi_rlast), .fifo_pop_last(fifo_pop_last),
		.blk_idle(blk_idle), .blk_done(blk_done),
		.araddr(m_axi_araddr), .arlen(m_axi_arlen), .arvalid(m_axi_arvalid),
		.in_flight_full(in_flight_full)
	);

	dsc_fifo u_fifo (
		.clk(clk), .rst_n(rst_n),
		.in_data(m_axi_rdata), .in_last(m_axi_rlast), .in_valid(m_axi_rvalid),
		.in_ready(m_axi_rready),
		.out_data(fifo_data), .out_last(fifo_last), .out_valid(fifo_valid),
		.out_ready(fifo_ready)
	);

	dsc_dispatch u_dispatch (
		.clk(clk), .rst_n(rst_n),
		.in_data(fifo_data), .in_valid(fifo_valid), .in_ready(fifo_ready),
		.chan_dsc(chan_dsc), .chan_valid(chan_valid), .chan_ready(chan_ready)
	);

	for (genvar i = 0; i < CHAN_N; i++)
	begin : g_split
		burst_cmd_splitter u_split (
			.clk(clk), .rst_n(rst_n),
			.dsc(chan_dsc), .dsc_valid(chan_valid[i]), .dsc_ready(chan_ready[i]),
			.cmd(split_cmd[i]), .cmd_valid(split_valid[i]), .cmd_ready(split_ready[i])
		);
	end

	cmd_arbiter u_arb (
		.clk(clk), .rst_n(rst_n),
		.in_cmd(split_cmd), .in_valid(split_valid), .in_ready(split_ready),
		.out_cmd(cmd), .out_chan(cmd_chan), .out_valid(cmd_valid), .out_ready(cmd_ready)
	);

	// a full buffer means the burst budget is used up, so AR is already stopped
	a_room_rule: assert property (@(posedge clk) disable iff (!rst_n)
		!m_axi_rready |-> in_flight_full);

endmodule

// ==== tb/axi_rd_mem_model.sv ====
module axi_rd_mem_model (
	input  logic                   clk,
	input  logic                   rst_n,
	input  dsc_dma_pkg::addr_t     araddr,
	input  logic [7:0]             arlen,
	input  logic                   arvalid,
	output logic                   arready,
	output dsc_dma_pkg::dsc_word_t rdata,
	output logic [1:0]             rresp,
	output logic                   rlast,
	output logic                   rvalid,
	input  logic                   rready
);
	timeunit 1ns;
	timeprecision 1ps;
	import dsc_dma_pkg::*;

	localparam int TBL_WORDS = 256; // 2KB window, address bits 10:3

	dsc_word_t   tbl [TBL_WORDS];   // descriptor table, read by the testbench too
	rd_dsc_t     fill;
	logic [31:0] rnd;
	int          seed = 32'h64ac_086b;
	logic [7:0]  widx;              // word of the current beat
	logic [7:0]  beat;
	logic [7:0]  blen;
	logic        busy;              // burst accepted, beats still owed

	// high three cycles in four
	function automatic logic coin();
		logic [31:0] r;
		r = $random(seed);
		return r[0] | r[1];
	endfunction

	initial
	begin
		for (int i = 0; i < TBL_WORDS; i++)
		begin
			rnd           = $random(seed);
			fill.byte_cnt = byte_cnt_t'(32'd1 + rnd % 32'd1000); // 1 to 1000 bytes
			rnd           = $random(seed);
			fill.addr     = rnd;
			rnd           = $random(seed);
			fill.tgt      = rnd[1:0];  // all four types, 3 included
			fill.pkt_info = rnd[3:2];
			tbl[i]        = fill;
		end
	end

	assign rdata = tbl[widx];
	assign rresp = 2'b00;       // always OKAY
	assign rlast = beat == blen;

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			busy    <= 1'b0;
			widx    <= '0;
			beat    <= '0;
			blen    <= '0;
		end
		else
		begin
			if (arvalid && arready)
			begin
				busy    <= 1'b1;
				widx    <= araddr[10:3];
				beat    <= '0;
				blen    <= arlen;
				arready <= 1'b0;
			end
			else
				arready <= !busy && coin(); // one burst at a time
			if (rvalid && rready)
			begin
				widx   <= widx + 8'd1;
				beat   <= beat + 8'd1;
				busy   <= !rlast;
				rvalid <= !rlast && coin();
			end
			else if (busy && !rvalid)
				rvalid <= coin();           // gap before the next beat
		end
	end

endmodule

// ==== tb/tb_dsc_dma.sv ====
module tb_dsc_dma;
	timeunit 1ns;
	timeprecision 1ps;
	import dsc_dma_pkg::*;

	localparam int RUN1_N         = 13;
	localparam int RUN2_N         = 37; // long enough to hit the burst budget
	localparam int TIMEOUT_CYCLES = 40 * (RUN1_N + RUN2_N) + 200;
	localparam int EXP_DEPTH      = 512;
	localparam int ERR_AR         = 0;
	localparam int ERR_CMD        = 1;
	localparam int ERR_BLK        = 2;

	logic        clk;
	logic        rst_n;
	addr_t       req_buf_baseaddr;
	logic [31:0] req_n;
	logic        blk_start;
	logic        blk_idle;
	logic        blk_done;
	addr_t       m_axi_araddr;
	logic [1:0]  m_axi_arburst;
	logic [7:0]  m_axi_arlen;
	logic [2:0]  m_axi_arsize;
	logic        m_axi_arvalid;
	logic        m_axi_arready;
	dsc_word_t   m_axi_rdata;
	logic [1:0]  m_axi_rresp;
	logic        m_axi_rlast;
	logic        m_axi_rvalid;
	logic        m_axi_rready;
	burst_cmd_t  cmd;
	chan_t       cmd_chan;
	logic        cmd_valid;
	logic        cmd_ready = 1'b0;

	burst_cmd_t  exp_cmds [4][EXP_DEPTH];   // per channel queues, row 3 stays empty
	int          exp_wr [4] = '{default: 0};
	int          exp_rd [4] = '{default: 0};
	addr_t       exp_araddr;
	logic [7:0]  exp_arlen;
	int          ar_rem = 0;                // descriptors not yet covered by an AR
	int          ar_cnt = 0;
	int          exp_bursts = 0;
	logic        burst_open = 1'b0;
	logic        done_seen = 1'b0;
	int          done_cnt = 0;
	int          errs [3] = '{default: 0};
	int          cycle_cnt = 0;
	int          seed = 32'h64ac_086b;
	logic [31:0] rnd;

	dsc_dma_top dsc_dma_top_inst (.*);

	axi_rd_mem_model mem_model (
		.clk(clk), .rst_n(rst_n),
		.araddr(m_axi_araddr), .arlen(m_axi_arlen), .arvalid(m_axi_arvalid),
		.arready(m_axi_arready),
		.rdata(m_axi_rdata), .rresp(m_axi_rresp), .rlast(m_axi_rlast),
		.rvalid(m_axi_rvalid), .rready(m_axi_rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic count_mismatch(input int kind, input string sig,
		input logic [63:0] exp_val, input logic [63:0] got_val);
		errs[kind]++;
		$display("CHECK FAILED t=%0t %s exp=%0h got=%0h", $time, sig, exp_val, got_val);
	endtask

	task automatic report_failure(input int kind, input string msg);
		errs[kind]++;
		$display("t=%0t %s", $time, msg);
	endtask

	task automatic print_summary();
		$display("errors: ar %0d, cmd %0d, blk %0d", errs[ERR_AR], errs[ERR_CMD], errs[ERR_BLK]);
	endtask

	// expected commands of n table entries, split in 256 byte pieces
	task automatic add_expected(input addr_t base, input int n);
		rd_dsc_t    d;
		burst_cmd_t c;
		addr_t      a;
		int         rem;
		int         row;
		for (int i = 0; i < n; i++)
		begin
			d   = mem_model.tbl[(int'(base[10:3]) + i) % 256];
			row = int'(d.tgt);
			a   = d.addr;
			rem = int'(d.byte_cnt);
			while (d.tgt != 2'd3 && rem > 0) // target 3 yields nothing
			begin
				c.addr     = a;
				c.len      = (rem > CMD_MAX_BYTES) ? cmd_len_t'(CMD_MAX_BYTES) : cmd_len_t'(rem);
				c.pkt_info = d.pkt_info;
				c.last     = rem <= CMD_MAX_BYTES;
				exp_cmds[row][exp_wr[row]] = c;
				exp_wr[row] = exp_wr[row] + 1;
				a   = a + addr_t'(CMD_MAX_BYTES);
				rem = rem - CMD_MAX_BYTES;
			end
		end
	endtask

	function automatic logic drained();
		logic ok;
		ok = 1'b1;
		for (int r = 0; r < CHAN_N; r++)
			ok = ok && (exp_rd[r] == exp_wr[r]);
		return ok;
	endfunction

	// one block run, back when blk_done was seen and every command came out
	task automatic run_block(input addr_t base, input int n);
		int done_target;
		done_target = done_cnt + 1;
		add_expected(base, n);
		@(posedge clk);
		req_buf_baseaddr <= base;
		req_n            <= 32'(n - 1);
		blk_start        <= 1'b1;
		@(posedge clk);
		blk_start <= 1'b0;
		while (done_cnt < done_target || !drained())
			@(posedge clk);
	endtask

	initial
	begin
		rst_n            = 1'b0;
		req_buf_baseaddr = '0;
		req_n            = '0;
		blk_start        = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		run_block(32'h0000_0040, RUN1_N);
		run_block(32'h0000_0600, RUN2_N); // new base and count
		repeat (20) @(posedge clk);        // room for a stray extra command
		print_summary();
		if (errs[ERR_AR] + errs[ERR_CMD] + errs[ERR_BLK] == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	always @(posedge clk)
	begin
		rnd = $random(seed);
		cmd_ready <= rnd[0]; // stalls half the cycles
	end

	assign exp_arlen = (ar_rem > DSC_BURST_LEN) ? 8'(DSC_BURST_LEN - 1) : 8'(ar_rem - 1);

	// scoreboard state, follows the handshakes
	always @(posedge clk)
	begin
		if (blk_start && blk_idle)
		begin
			exp_araddr <= req_buf_baseaddr;
			ar_rem     <= int'(req_n) + 1;
			ar_cnt     <= 0;
			exp_bursts <= (int'(req_n) + DSC_BURST_LEN) / DSC_BURST_LEN; // ceil(n/8)
			done_seen  <= 1'b0;
		end
		else if (m_axi_arvalid && m_axi_arready)
		begin
			exp_araddr <= exp_araddr + 32'd64;
			ar_rem     <= (ar_rem > DSC_BURST_LEN) ? ar_rem - DSC_BURST_LEN : 0;
			ar_cnt     <= ar_cnt + 1;
		end
		if (m_axi_arvalid && m_axi_arready)
			burst_open <= 1'b1;
		else if (m_axi_rvalid && m_axi_rready && m_axi_rlast)
			burst_open <= 1'b0;
		if (blk_done)
		begin
			done_seen <= 1'b1;
			done_cnt  <= done_cnt + 1;
		end
		if (cmd_valid && cmd_ready && exp_rd[cmd_chan] < exp_wr[cmd_chan])
			exp_rd[cmd_chan] <= exp_rd[cmd_chan] + 1; // pop
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
		begin
			$display("timeout, run not finished after %0d cycles", cycle_cnt);
			print_summary();
			$display("** FAIL **");
			$finish;
		end
	end

	a_araddr: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_arvalid |-> m_axi_araddr == exp_araddr)
		else count_mismatch(ERR_AR, "m_axi_araddr", 64'(exp_araddr), 64'(m_axi_araddr));

	a_arlen: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_arvalid |-> m_axi_arlen == exp_arlen)
		else count_mismatch(ERR_AR, "m_axi_arlen", 64'(exp_arlen), 64'(m_axi_arlen));

	a_ar_fixed: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_arvalid |-> m_axi_arburst == 2'b01 && m_axi_arsize == 3'b011)
		else report_failure(ERR_AR, "AR burst type or beat size is not INCR of 8 bytes");

	// no AR past the table end, none while a burst is still open
	a_ar_gate: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_arvalid |-> ar_rem != 0 && !burst_open)
		else report_failure(ERR_AR, "AR issued with no descriptors left or over an open burst");

	// four bursts of eight fit the 32 word buffer, so no beat waits for room
	a_r_room: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_rvalid |-> m_axi_rready)
		else count_mismatch(ERR_AR, "m_axi_rready", 64'd1, 64'(m_axi_rready));

	a_burst_cnt: assert property (@(posedge clk) disable iff (!rst_n)
		blk_done |-> ar_cnt == exp_bursts)
		else count_mismatch(ERR_AR, "AR burst count", 64'(exp_bursts), 64'(ar_cnt));

	// also catches target 3 and duplicates
	a_cmd_known: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid && cmd_ready |-> exp_rd[cmd_chan] < exp_wr[cmd_chan])
		else report_failure(ERR_CMD, $sformatf("command on channel %0d that expects none",
			cmd_chan));

	a_cmd_value: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid && cmd_ready && exp_rd[cmd_chan] < exp_wr[cmd_chan]
		|-> cmd == exp_cmds[cmd_chan][exp_rd[cmd_chan]])
		else count_mismatch(ERR_CMD, $sformatf("cmd (chan %0d)", cmd_chan),
			64'(exp_cmds[cmd_chan][exp_rd[cmd_chan]]), 64'(cmd));

	a_cmd_len: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |-> cmd.len != '0 && cmd.len <= cmd_len_t'(CMD_MAX_BYTES))
		else report_failure(ERR_CMD, "command length outside 1 to 256 bytes");

	a_done_once: assert property (@(posedge clk) disable iff (!rst_n)
		blk_done |-> !done_seen)
		else report_failure(ERR_BLK, "blk_done pulsed more than once in a run");

	a_idle_after: assert property (@(posedge clk) disable iff (!rst_n)
		blk_done |=> blk_idle)
		else count_mismatch(ERR_BLK, "blk_idle", 64'd1, 64'(blk_idle));

endmodule

// ==== sources.f ====
hdl/dsc_dma_pkg.sv
hdl/rw_req_dsc_fetch.sv
hdl/dsc_fifo.sv
hdl/dsc_dispatch.sv
hdl/burst_cmd_splitter.sv
hdl/cmd_arbiter.sv
hdl/dsc_dma_top.sv
tb/axi_rd_mem_model.sv
tb/tb_dsc_dma.sv

// ==== Makefile ====
# descriptor DMA front end, Verilator simulation

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dsc_dma \
		-f sources.f -Mdir obj_dir -o tb_dsc_dma

run: compile
	@out="$$(./obj_dir/tb_dsc_dma)"; echo "$$out"; \
		echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir
